/* Makefile */
# Verilator build and run for the paired decode stage

VERILATOR ?= verilator
TOP       ?= tb_warp_decode
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FILELIST  ?= all.f
VFLAGS    ?= --binary --assert -j 0

SRCS := $(shell grep -v '^+' $(FILELIST))
HDRS := $(wildcard verilog/*.svh bench/*.svh)
SIM  := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM)

# rebuilt only when a source, header or the file list changes
$(SIM): $(FILELIST) $(SRCS) $(HDRS)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

# pass only if the log holds the pass line
run: $(SIM)
	./$(SIM) | tee $(LOG)
	grep -q '^\*\* PASS \*\*$$' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* all.f */
+incdir+verilog
+incdir+bench
verilog/warp_isa_pkg.sv
verilog/warp_decode_pkg.sv
verilog/warp_bundle_if.sv
verilog/warp_imm_gen.sv
verilog/warp_udecode.sv
verilog/warp_skid.sv
verilog/warp_decode.sv
bench/tb_warp_decode.sv

/* bench/warp_decode_model.svh */
`ifndef WARP_DECODE_MODEL_SVH
`define WARP_DECODE_MODEL_SVH

// reference immediate for each RISC-V format
// sign always comes from inst[31]
function automatic logic [`WARP_IMM_W-1:0] expected_imm(input logic [`WARP_INST_W-1:0] w);
    logic [31:0] s;
    s = {32{w[31]}};
    case (w[6:2])
        OPC_OP_IMM, OPC_OP_IMM_32, OPC_JALR, OPC_LOAD: begin
            expected_imm = {s[31:12], w[31:20]};
        end
        OPC_STORE: begin
            expected_imm = {s[31:12], w[31:25], w[11:7]};
        end
        // branch offset, bit 0 implied
        OPC_BRANCH: begin
            expected_imm = {s[31:13], w[31], w[7], w[30:25], w[11:8], 1'b0};
        end
        OPC_LUI, OPC_AUIPC: begin
            expected_imm = {w[31:12], 12'h000};
        end
        OPC_JAL: begin
            expected_imm = {s[31:21], w[31], w[19:12], w[20], w[30:21], 1'b0};
        end
        // R format slices only
        default: begin
            expected_imm = {s[31:12], w[31:25], 5'b00000};
        end
    endcase
endfunction

// base alu split by funct3
function automatic decode_bundle_t alu_fields(input decode_bundle_t b, input logic [2:0] f3);
    decode_bundle_t r;
    r = b;
    case (f3)
        3'b000: begin
            r.pipe      = PIPE_XARITH;
            r.xarith.op = XARITH_ADD;
        end
        3'b010, 3'b011: begin
            r.pipe               = PIPE_XARITH;
            r.xarith.op          = XARITH_SLT;
            r.xarith.is_unsigned = f3[0];
        end
        3'b001, 3'b101: begin
            r.pipe      = PIPE_XLOGIC;
            r.xlogic.op = XLOGIC_SHF;
        end
        3'b100: begin
            r.pipe      = PIPE_XLOGIC;
            r.xlogic.op = XLOGIC_XOR;
        end
        3'b110: begin
            r.pipe      = PIPE_XLOGIC;
            r.xlogic.op = XLOGIC_OR;
        end
        default: begin
            r.pipe      = PIPE_XLOGIC;
            r.xlogic.op = XLOGIC_AND;
        end
    endcase
    return r;
endfunction

// full expected bundle for one instruction word
function automatic decode_bundle_t expected_bundle(input logic [`WARP_INST_W-1:0] w);
    decode_bundle_t b;
    logic [2:0]     f3;
    logic [6:0]     f7;
    b     = '0;
    f3    = w[14:12];
    f7    = w[31:25];
    b.rs1 = w[19:15];
    b.rs2 = w[24:20];
    b.rd  = w[11:7];
    b.imm = expected_imm(w);
    case (w[6:2])
        OPC_OP_IMM: begin
            // shifts check the upper six bits, shamt[5] is free
            if (f3 == 3'b001)
                b.legal = (w[31:26] == 6'h00);
            else if (f3 == 3'b101)
                b.legal = (w[31:26] == 6'h00) || (w[31:26] == 6'h10);
            else
                b.legal = 1'b1;
            b = alu_fields(b, f3);
        end
        OPC_OP_IMM_32: begin
            b.legal = (f3 == 3'b000) || (f3 == 3'b001 && f7 == 7'h00) ||
                      (f3 == 3'b101 && (f7 == 7'h00 || f7 == 7'h20));
            b = alu_fields(b, f3);
        end
        OPC_OP: begin
            b.legal = (f7 == 7'h00) || (f7 == 7'h01) ||
                      (f7 == 7'h20 && (f3 == 3'b000 || f3 == 3'b101));
            if (f7[0]) begin
                if (f3 == 3'b000)
                    b.pipe = PIPE_XMULTL;
                else if (f3[2])
                    b.pipe = PIPE_XDIV;
                else
                    b.pipe = PIPE_XMULTH;
            end else begin
                b = alu_fields(b, f3);
                b.xarith.sub = (b.pipe == PIPE_XARITH) && f7[5];
            end
        end
        OPC_OP_32: begin
            b.legal = (f3 == 3'b000 && (f7 == 7'h00 || f7 == 7'h20 || f7 == 7'h01)) ||
                      (f3 == 3'b001 && f7 == 7'h00) ||
                      (f3 == 3'b101 && (f7 == 7'h00 || f7 == 7'h20));
            if (f7[0]) begin
                b.pipe = PIPE_XMULTL;
            end else begin
                b = alu_fields(b, f3);
                b.xarith.sub = (b.pipe == PIPE_XARITH) && f7[5];
            end
        end
        OPC_LUI, OPC_AUIPC: begin
            b.legal     = 1'b1;
            b.pipe      = PIPE_XARITH;
            b.xarith.op = XARITH_ADD;
        end
        default: b.legal = 1'b0;
    endcase
    // illegal keeps regs and imm only
    if (!b.legal) begin
        b.pipe   = PIPE_NONE;
        b.xarith = '0;
        b.xlogic = '0;
    end
    return b;
endfunction

`endif

/* bench/tb_warp_decode.sv */
`default_nettype none

`include "warp_decode_macros.svh"

module tb_warp_decode
    import warp_isa_pkg::*;
    import warp_decode_pkg::*;
();

    `include "warp_decode_model.svh"

    localparam int N_RAND   = 300;
    localparam int N_HS     = 400;
    // reset, about 200 directed pairs, random pairs, random handshake
    localparam int STIM_CYC = 8 + 200 + N_RAND + N_HS;
    localparam int MAX_CYC  = 4 * STIM_CYC;

    localparam logic [4:0] INT_OPS [4] = '{OPC_OP, OPC_OP_32, OPC_OP_IMM, OPC_OP_IMM_32};
    localparam logic [4:0] FMT_OPS [10] = '{
        OPC_LUI, OPC_AUIPC, OPC_LOAD, OPC_STORE, OPC_BRANCH,
        OPC_JAL, OPC_JALR, OPC_SYSTEM, OPC_MISC_MEM, OPC_AMO
    };
    // funct7 patterns, legal ones plus near misses
    localparam logic [6:0] F7_SET [7] = '{7'h00, 7'h20, 7'h01, 7'h21, 7'h40, 7'h7f, 7'h02};

    logic                    i_clk;
    logic                    i_rst_n;
    logic                    i_input_valid;
    logic                    o_input_ready;
    logic [`WARP_INST_W-1:0] i_inst0;
    logic [`WARP_INST_W-1:0] i_inst1;
    logic                    o_output_valid;
    logic                    i_output_ready;
    decode_bundle_t          o_bundle0;
    decode_bundle_t          o_bundle1;

    decode_bundle_t          exp0_q[$];
    decode_bundle_t          exp1_q[$];
    logic [`WARP_INST_W-1:0] dir_q[$];
    logic                    rst_q;
    logic                    steady;
    int                      val_errs;
    int                      proto_errs;
    int                      n_issued;
    int                      cycle_cnt;
    int unsigned             seed;

    warp_decode warp_decode_inst (
        .i_clk          (i_clk),
        .i_rst_n        (i_rst_n),
        .i_input_valid  (i_input_valid),
        .o_input_ready  (o_input_ready),
        .i_inst0        (i_inst0),
        .i_inst1        (i_inst1),
        .o_output_valid (o_output_valid),
        .i_output_ready (i_output_ready),
        .o_bundle0      (o_bundle0),
        .o_bundle1      (o_bundle1)
    );

    always #50 i_clk = ~i_clk;

    // random word for one of the interesting opcodes
    function automatic logic [`WARP_INST_W-1:0] random_inst();
        logic [31:0] r;
        logic [4:0]  opc;
        r = $urandom();
        if ($urandom_range(0, 1) != 0)
            opc = INT_OPS[$urandom_range(0, 3)];
        else
            opc = FMT_OPS[$urandom_range(0, 9)];
        // half the time force a meaningful funct7
        if (r[0])
            r[31:25] = F7_SET[$urandom_range(0, 6)];
        return {r[31:7], opc, 2'b11};
    endfunction

    // every int funct3/funct7 combination, then format opcodes with random fields
    task automatic build_directed();
        logic [31:0] r;
        for (int o = 0; o < 4; o++) begin
            for (int f3 = 0; f3 < 8; f3++) begin
                for (int k = 0; k < 7; k++) begin
                    r = $urandom();
                    dir_q.push_back({F7_SET[k], r[24:15], f3[2:0], r[11:7], INT_OPS[o], 2'b11});
                end
            end
        end
        for (int o = 0; o < 10; o++) begin
            repeat (16) begin
                r = $urandom();
                dir_q.push_back({r[31:7], FMT_OPS[o], 2'b11});
            end
        end
    endtask

    // present a pair and hold it until taken
    task automatic send_pair(input logic [31:0] a, input logic [31:0] b);
        i_input_valid <= 1'b1;
        i_inst0       <= a;
        i_inst1       <= b;
        @(posedge i_clk);
        while (!o_input_ready)
            @(posedge i_clk);
    endtask

    task automatic report_counts();
        $display("pairs issued %0d, value errors %0d, protocol errors %0d",
                 n_issued, val_errs, proto_errs);
    endtask

    // scoreboard, reset is active high
    always @(posedge i_clk) begin
        rst_q <= i_rst_n;
        if (!i_rst_n) begin
            // check issue first, a pair never leaves on its own accept edge
            if (o_output_valid && i_output_ready) begin
                a_issue_known: assert (exp0_q.size() != 0) else begin
                    proto_errs++;
                    $display("pair issued with no accepted pair outstanding");
                end
                if (exp0_q.size() != 0) begin
                    a_slot0: assert (o_bundle0 === exp0_q[0]) else begin
                        val_errs++;
                        $display("FAIL o_bundle0 expected 0x%h got 0x%h", exp0_q[0], o_bundle0);
                    end
                    a_slot1: assert (o_bundle1 === exp1_q[0]) else begin
                        val_errs++;
                        $display("FAIL o_bundle1 expected 0x%h got 0x%h", exp1_q[0], o_bundle1);
                    end
                    void'(exp0_q.pop_front());
                    void'(exp1_q.pop_front());
                    n_issued++;
                end
            end
            if (i_input_valid && o_input_ready) begin
                exp0_q.push_back(expected_bundle(i_inst0));
                exp1_q.push_back(expected_bundle(i_inst1));
            end
        end
    end

    // reset state, seen one edge after reset was sampled
    a_reset_state: assert property (@(posedge i_clk) rst_q |-> (!o_output_valid && o_input_ready))
        else begin
            proto_errs++;
            $display("output valid or input not ready during reset");
        end

    // accept into an empty or draining output shows up next cycle
    a_latency: assert property (@(posedge i_clk) disable iff (i_rst_n)
        (i_input_valid && o_input_ready && (!o_output_valid || i_output_ready)) |=> o_output_valid)
        else begin
            proto_errs++;
            $display("accepted pair did not reach the output one cycle later");
        end

    a_hold: assert property (@(posedge i_clk) disable iff (i_rst_n)
        (o_output_valid && !i_output_ready) |=>
        (o_output_valid && $stable(o_bundle0) && $stable(o_bundle1)))
        else begin
            proto_errs++;
            $display("stalled output pair changed before it was taken");
        end

    // ready only falls when a stalled output takes one more pair
    a_ready_fall: assert property (@(posedge i_clk) disable iff (i_rst_n)
        (o_input_ready && !(i_input_valid && o_output_valid && !i_output_ready)) |=> o_input_ready)
        else begin
            proto_errs++;
            $display("input ready fell without a pair entering the skid buffer");
        end

    a_skid_take: assert property (@(posedge i_clk) disable iff (i_rst_n)
        (o_input_ready && i_input_valid && o_output_valid && !i_output_ready) |=> !o_input_ready)
        else begin
            proto_errs++;
            $display("input ready stayed high with the skid buffer full");
        end

    a_ready_back: assert property (@(posedge i_clk) disable iff (i_rst_n)
        (!o_input_ready && i_output_ready) |=> o_input_ready)
        else begin
            proto_errs++;
            $display("input ready did not return after the skid pair drained");
        end

    // issue ready held high, one pair every cycle
    a_steady: assert property (@(posedge i_clk) disable iff (i_rst_n) steady |-> o_input_ready)
        else begin
            proto_errs++;
            $display("input stalled while issue was always ready");
        end

    always @(posedge i_clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= MAX_CYC) begin
            $display("timeout, run did not finish within %0d cycles", MAX_CYC);
            report_counts();
            $display("** FAIL **");
            $finish;
        end
    end

    initial begin
        logic [31:0] a;
        logic [31:0] b;
        seed           = $urandom(53);
        i_clk          = 1'b0;
        i_rst_n        = 1'b1;
        // a pair offered during reset must never reach the output
        i_input_valid  = 1'b1;
        i_output_ready = 1'b1;
        i_inst0        = '0;
        i_inst1        = '0;
        rst_q          = 1'b0;
        steady         = 1'b1;
        val_errs       = 0;
        proto_errs     = 0;
        n_issued       = 0;
        cycle_cnt      = 0;
        build_directed();
        repeat (6) @(posedge i_clk);
        i_input_valid <= 1'b0;
        repeat (2) @(posedge i_clk);
        i_rst_n <= 1'b0;

        // directed pairs back to back
        while (dir_q.size() >= 2) begin
            a = dir_q.pop_front();
            b = dir_q.pop_front();
            send_pair(a, b);
        end
        // random pairs, issue still always ready
        for (int n = 0; n < N_RAND; n++)
            send_pair(random_inst(), random_inst());

        // random valid and ready on both sides
        steady <= 1'b0;
        for (int c = 0; c < N_HS; c++) begin
            // a pending pair stays put until taken
            if (!i_input_valid || o_input_ready) begin
                i_input_valid <= ($urandom_range(0, 3) != 0);
                i_inst0       <= random_inst();
                i_inst1       <= random_inst();
            end
            i_output_ready <= ($urandom_range(0, 2) != 0);
            @(posedge i_clk);
        end

        // drain, a lost pair ends in the timeout
        i_input_valid  <= 1'b0;
        i_output_ready <= 1'b1;
        @(negedge i_clk);
        while (exp0_q.size() != 0 || o_output_valid)
            @(negedge i_clk);
        repeat (2) @(posedge i_clk);

        report_counts();
        if (val_errs == 0 && proto_errs == 0 && n_issued != 0)
            $display("** PASS **");
        else
            $display("** FAIL **");
        $finish;
    end

endmodule

`default_nettype wire

/* verilog/warp_bundle_if.sv */
`default_nettype none

// decoded pair from the two decoders into the skid buffer
interface warp_bundle_if
    import warp_decode_pkg::*;
();

    logic           valid;
    logic           ready;
    decode_bundle_t bundle0;
    decode_bundle_t bundle1;

    // decode side
    modport producer (output valid, output bundle0, output bundle1, input ready);

    // skid buffer side
    modport consumer (input valid, input bundle0, input bundle1, output ready);

endinterface

`default_nettype wire

/* verilog/warp_decode.sv */
`default_nettype none

`include "warp_decode_macros.svh"

module warp_decode
    import warp_decode_pkg::*;
(
    input  wire                    i_clk,
    input  wire                    i_rst_n,
    // fetch side, pads with a nop when only one inst is available
    input  wire                    i_input_valid,
    output logic                   o_input_ready,
    input  wire [`WARP_INST_W-1:0] i_inst0,
    input  wire [`WARP_INST_W-1:0] i_inst1,
    // issue side
    output logic                   o_output_valid,
    input  wire                    i_output_ready,
    output decode_bundle_t         o_bundle0,
    output decode_bundle_t         o_bundle1
);

    warp_bundle_if dec_pair ();

    // fetch handshake passes through to the skid buffer
    assign dec_pair.valid = i_input_valid;
    assign o_input_ready  = dec_pair.ready;

    // slot 0, older instruction
    warp_udecode u_dec0 (
        .i_inst   (i_inst0),
        .o_bundle (dec_pair.bundle0)
    );

    // slot 1
    warp_udecode u_dec1 (
        .i_inst   (i_inst1),
        .o_bundle (dec_pair.bundle1)
    );

    // holds pairs while issue stalls
    warp_skid u_skid (
        .i_clk          (i_clk),
        .i_rst_n        (i_rst_n),
        .in_pair        (dec_pair),
        .o_output_valid (o_output_valid),
        .i_output_ready (i_output_ready),
        .o_bundle0      (o_bundle0),
        .o_bundle1      (o_bundle1)
    );

endmodule

`default_nettype wire

/* verilog/warp_decode_macros.svh */
`ifndef WARP_DECODE_MACROS_SVH
`define WARP_DECODE_MACROS_SVH

// raw 32-bit instruction word from fetch
`define WARP_INST_W 32

// architectural register address, x0..x31
`define WARP_REG_W 5

// immediate as carried in the bundle
// sign extension to 64 bits happens in the backend
`define WARP_IMM_W 32

// instructions decoded together per cycle
`define WARP_ISSUE_W 2

`endif

/* verilog/warp_decode_pkg.sv */
`default_nettype none

`include "warp_decode_macros.svh"

package warp_decode_pkg;

    // backend pipeline class
    // zero means no pipe, used for illegal instructions
    typedef enum logic [3:0] {
        PIPE_NONE   = 4'd0,
        PIPE_XARITH = 4'd1,
        PIPE_XLOGIC = 4'd2,
        PIPE_XMULTL = 4'd3,
        PIPE_XMULTH = 4'd4,
        PIPE_XDIV   = 4'd5
    } pipe_e;

    // xarith unit op select
    typedef enum logic [1:0] {
        XARITH_ADD = 2'd0,
        XARITH_SLT = 2'd1
    } xarith_op_e;

    // xlogic unit op select
    typedef enum logic [2:0] {
        XLOGIC_AND = 3'd0,
        XLOGIC_OR  = 3'd1,
        XLOGIC_XOR = 3'd2,
        XLOGIC_SHF = 3'd3
    } xlogic_op_e;

    typedef struct packed {
        xarith_op_e op;
        logic       sub;
        // compare as unsigned, sltu / sltiu
        logic       is_unsigned;
    } xarith_ctrl_t;

    typedef struct packed {
        xlogic_op_e op;
        logic       invert;
    } xlogic_ctrl_t;

    // one decoded instruction as handed to issue
    typedef struct packed {
        logic                    legal;
        logic [`WARP_REG_W-1:0]  rd;
        logic [`WARP_REG_W-1:0]  rs2;
        logic [`WARP_REG_W-1:0]  rs1;
        logic [`WARP_IMM_W-1:0]  imm;
        pipe_e                   pipe;
        xarith_ctrl_t            xarith;
        xlogic_ctrl_t            xlogic;
    } decode_bundle_t;

endpackage

`default_nettype wire

/* verilog/warp_imm_gen.sv */
`default_nettype none

`include "warp_decode_macros.svh"

module warp_imm_gen
    import warp_isa_pkg::*;
(
    input  wire [`WARP_INST_W-1:0] i_inst,
    output logic [`WARP_IMM_W-1:0] o_imm
);

    opcode_e opcode;
    logic    sign;

    assign opcode = opcode_e'(i_inst[6:2]);
    // every format takes its sign from bit 31
    assign sign = i_inst[31];

    always_comb begin
        case (opcode)
            // I format, loads, jalr and the imm alu ops
            OPC_OP_IMM, OPC_OP_IMM_32, OPC_JALR, OPC_LOAD: begin
                o_imm = {{(`WARP_IMM_W-11){sign}}, i_inst[30:20]};
            end
            // S format, offset split around rs2
            OPC_STORE: begin
                o_imm = {{(`WARP_IMM_W-11){sign}}, i_inst[30:25], i_inst[11:7]};
            end
            // B format
            // bit 11 lives in inst[7], bit 0 is implied zero
            OPC_BRANCH: begin
                o_imm = {{(`WARP_IMM_W-12){sign}}, i_inst[7], i_inst[30:25],
                         i_inst[11:8], 1'b0};
            end
            // U format, upper 20 bits, low 12 zero
            OPC_LUI, OPC_AUIPC: begin
                o_imm = {{(`WARP_IMM_W-31){sign}}, i_inst[30:12], 12'b0};
            end
            // J format, scrambled 20-bit offset
            OPC_JAL: begin
                o_imm = {{(`WARP_IMM_W-20){sign}}, i_inst[19:12], i_inst[20],
                         i_inst[30:21], 1'b0};
            end
            // R format and the rest
            // only the funct7 slice lands in the immediate
            default: begin
                o_imm = {{(`WARP_IMM_W-11){sign}}, i_inst[30:25], 5'b0};
            end
        endcase
    end

endmodule

`default_nettype wire

/* verilog/warp_isa_pkg.sv */
`default_nettype none

package warp_isa_pkg;

    // major opcode, inst[6:2]
    // inst[1:0] is always 2'b11 for uncompressed encodings
    typedef enum logic [4:0] {
        OPC_LOAD      = 5'b00000,
        OPC_LOAD_FP   = 5'b00001,
        OPC_MISC_MEM  = 5'b00011,
        OPC_OP_IMM    = 5'b00100,
        OPC_AUIPC     = 5'b00101,
        OPC_OP_IMM_32 = 5'b00110,
        OPC_STORE     = 5'b01000,
        OPC_STORE_FP  = 5'b01001,
        OPC_AMO       = 5'b01011,
        OPC_OP        = 5'b01100,
        OPC_LUI       = 5'b01101,
        OPC_OP_32     = 5'b01110,
        OPC_MADD      = 5'b10000,
        OPC_MSUB      = 5'b10001,
        OPC_NMSUB     = 5'b10010,
        OPC_NMADD     = 5'b10011,
        OPC_OP_FP     = 5'b10100,
        OPC_BRANCH    = 5'b11000,
        OPC_JALR      = 5'b11001,
        OPC_JAL       = 5'b11011,
        OPC_SYSTEM    = 5'b11100
    } opcode_e;

    // funct3 names for the integer op groups
    typedef enum logic [2:0] {
        F3_ADD_SUB = 3'b000,
        F3_SLL     = 3'b001,
        F3_SLT     = 3'b010,
        F3_SLTU    = 3'b011,
        F3_XOR     = 3'b100,
        F3_SR      = 3'b101,
        F3_OR      = 3'b110,
        F3_AND     = 3'b111
    } funct3_e;

endpackage

`default_nettype wire

/* verilog/warp_skid.sv */
`default_nettype none

`include "warp_decode_macros.svh"

module warp_skid
    import warp_decode_pkg::*;
(
    input  wire                  i_clk,
    input  wire                  i_rst_n,
    warp_bundle_if.consumer      in_pair,
    output logic                 o_output_valid,
    input  wire                  i_output_ready,
    output decode_bundle_t       o_bundle0,
    output decode_bundle_t       o_bundle1
);

    // slot 0 in the low entry
    decode_bundle_t [`WARP_ISSUE_W-1:0] in_data;
    decode_bundle_t [`WARP_ISSUE_W-1:0] out_pair;
    decode_bundle_t [`WARP_ISSUE_W-1:0] skid_pair;
    logic                               out_valid;
    logic                               skid_valid;
    logic                               accept;
    logic                               drain;

    assign in_data = {in_pair.bundle1, in_pair.bundle0};

    // ready comes straight off the skid flop, no comb path from issue
    assign in_pair.ready = ~skid_valid;
    assign accept        = in_pair.valid && in_pair.ready;
    // output register free this cycle
    assign drain         = ~out_valid || i_output_ready;

    // control state
    always_ff @(posedge i_clk) begin
        if (i_rst_n) begin
            out_valid  <= 1'b0;
            skid_valid <= 1'b0;
        end else if (drain) begin
            // held pair goes first to keep order
            out_valid  <= skid_valid || accept;
            skid_valid <= 1'b0;
        end else if (accept) begin
            // output stalled, park the new pair
            skid_valid <= 1'b1;
        end
    end

    // payload, no reset
    always_ff @(posedge i_clk) begin
        if (drain) begin
            if (skid_valid)
                out_pair <= skid_pair;
            else if (accept)
                out_pair <= in_data;
        end
        if (!drain && accept)
            skid_pair <= in_data;
    end

    assign o_output_valid = out_valid;
    assign o_bundle0      = out_pair[0];
    assign o_bundle1      = out_pair[1];

endmodule

`default_nettype wire

/* verilog/warp_udecode.sv */
`default_nettype none

`include "warp_decode_macros.svh"

module warp_udecode
    import warp_isa_pkg::*;
    import warp_decode_pkg::*;
(
    input  wire [`WARP_INST_W-1:0] i_inst,
    output decode_bundle_t         o_bundle
);

    opcode_e                opcode;
    funct3_e                funct3;
    logic [6:0]             funct7;
    logic [`WARP_REG_W-1:0] rs1;
    logic [`WARP_REG_W-1:0] rs2;
    logic [`WARP_REG_W-1:0] rd;
    logic [`WARP_IMM_W-1:0] imm;

    logic                   legal;
    pipe_e                  pipe;
    xarith_ctrl_t           xarith;
    xlogic_ctrl_t           xlogic;

    // funct7 space is sparse, only these three patterns matter
    logic f7_none;
    logic f7_alt;
    logic f7_muldiv;
    // shift imm in OP_IMM carries shamt[5] in bit 25
    logic shamt_lo;
    logic shamt_alt;
    // sub only comes from register-register forms
    logic sub_en;

    assign opcode = opcode_e'(i_inst[6:2]);
    assign funct3 = funct3_e'(i_inst[14:12]);
    assign funct7 = i_inst[31:25];

    // register fields are always extracted, legal or not
    assign rs1 = i_inst[19:15];
    assign rs2 = i_inst[24:20];
    assign rd  = i_inst[11:7];

    assign f7_none   = funct7 == 7'b0000000;
    assign f7_alt    = funct7 == 7'b0100000;
    assign f7_muldiv = funct7 == 7'b0000001;
    assign shamt_lo  = i_inst[31:26] == 6'b000000;
    assign shamt_alt = i_inst[31:26] == 6'b010000;
    assign sub_en    = (opcode == OPC_OP) || (opcode == OPC_OP_32);

    warp_imm_gen u_imm_gen (
        .i_inst (i_inst),
        .o_imm  (imm)
    );

    always_comb begin
        legal  = 1'b0;
        pipe   = PIPE_NONE;
        xarith = '0;
        xlogic = '0;

        case (opcode)
            // addi slti sltiu xori ori andi slli srli srai
            OPC_OP_IMM: begin
                legal = 1'b1;
                case (funct3)
                    F3_ADD_SUB: begin
                        pipe      = PIPE_XARITH;
                        xarith.op = XARITH_ADD;
                    end
                    F3_SLT, F3_SLTU: begin
                        pipe      = PIPE_XARITH;
                        xarith.op = XARITH_SLT;
                    end
                    F3_SLL: begin
                        legal     = shamt_lo;
                        pipe      = PIPE_XLOGIC;
                        xlogic.op = XLOGIC_SHF;
                    end
                    F3_SR: begin
                        legal     = shamt_lo || shamt_alt;
                        pipe      = PIPE_XLOGIC;
                        xlogic.op = XLOGIC_SHF;
                    end
                    F3_XOR: begin
                        pipe      = PIPE_XLOGIC;
                        xlogic.op = XLOGIC_XOR;
                    end
                    F3_OR: begin
                        pipe      = PIPE_XLOGIC;
                        xlogic.op = XLOGIC_OR;
                    end
                    default: begin
                        pipe      = PIPE_XLOGIC;
                        xlogic.op = XLOGIC_AND;
                    end
                endcase
            end
            // addiw slliw srliw sraiw
            OPC_OP_IMM_32: begin
                case (funct3)
                    F3_ADD_SUB: begin
                        legal     = 1'b1;
                        pipe      = PIPE_XARITH;
                        xarith.op = XARITH_ADD;
                    end
                    F3_SLL: begin
                        legal     = f7_none;
                        pipe      = PIPE_XLOGIC;
                        xlogic.op = XLOGIC_SHF;
                    end
                    F3_SR: begin
                        legal     = f7_none || f7_alt;
                        pipe      = PIPE_XLOGIC;
                        xlogic.op = XLOGIC_SHF;
                    end
                    default: legal = 1'b0;
                endcase
            end
            // base alu ops plus the M extension
            OPC_OP: begin
                legal = f7_none || f7_muldiv ||
                        (f7_alt && (funct3 == F3_ADD_SUB || funct3 == F3_SR));
                if (funct7[0]) begin
                    // mul, then mulh*, then div/rem
                    if (funct3 == F3_ADD_SUB)
                        pipe = PIPE_XMULTL;
                    else if (!funct3[2])
                        pipe = PIPE_XMULTH;
                    else
                        pipe = PIPE_XDIV;
                end else begin
                    case (funct3)
                        F3_ADD_SUB: begin
                            pipe      = PIPE_XARITH;
                            xarith.op = XARITH_ADD;
                        end
                        F3_SLT, F3_SLTU: begin
                            pipe      = PIPE_XARITH;
                            xarith.op = XARITH_SLT;
                        end
                        F3_SLL, F3_SR: begin
                            pipe      = PIPE_XLOGIC;
                            xlogic.op = XLOGIC_SHF;
                        end
                        F3_XOR: begin
                            pipe      = PIPE_XLOGIC;
                            xlogic.op = XLOGIC_XOR;
                        end
                        F3_OR: begin
                            pipe      = PIPE_XLOGIC;
                            xlogic.op = XLOGIC_OR;
                        end
                        default: begin
                            pipe      = PIPE_XLOGIC;
                            xlogic.op = XLOGIC_AND;
                        end
                    endcase
                end
            end
            // addw subw mulw sllw srlw sraw
            OPC_OP_32: begin
                case (funct3)
                    F3_ADD_SUB: begin
                        legal     = f7_none || f7_alt || f7_muldiv;
                        pipe      = funct7[0] ? PIPE_XMULTL : PIPE_XARITH;
                        xarith.op = XARITH_ADD;
                    end
                    F3_SLL: begin
                        legal     = f7_none;
                        pipe      = PIPE_XLOGIC;
                        xlogic.op = XLOGIC_SHF;
                    end
                    F3_SR: begin
                        legal     = f7_none || f7_alt;
                        pipe      = PIPE_XLOGIC;
                        xlogic.op = XLOGIC_SHF;
                    end
                    default: legal = 1'b0;
                endcase
            end
            // lui adds to x0, auipc adds to pc
            OPC_LUI, OPC_AUIPC: begin
                legal     = 1'b1;
                pipe      = PIPE_XARITH;
                xarith.op = XARITH_ADD;
            end
            default: legal = 1'b0;
        endcase

        // arith flags only for the arith pipe
        if (pipe == PIPE_XARITH) begin
            xarith.sub         = sub_en && funct7[5];
            xarith.is_unsigned = (xarith.op == XARITH_SLT) && funct3[0];
        end else begin
            xarith = '0;
        end
        if (pipe != PIPE_XLOGIC)
            xlogic = '0;

        // illegal keeps regs and imm but no class or controls
        if (!legal) begin
            pipe   = PIPE_NONE;
            xarith = '0;
            xlogic = '0;
        end
    end

    assign o_bundle = '{
        legal:  legal,
        rd:     rd,
        rs2:    rs2,
        rs1:    rs1,
        imm:    imm,
        pipe:   pipe,
        xarith: xarith,
        xlogic: xlogic
    };

endmodule

`default_nettype wire
